// File: cpl_queue.sv
`timescale 1ns/10ps

/*
 * Completion queue.
 * Synchronous circular FIFO with valid/ready on both sides.
 * Head entry is presented combinationally on the output.
 */
module cpl_queue #(
  parameter int DATA_BITS = 12,
  parameter int DEPTH     = 8
) (
  input  logic                 aclk,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_BITS-1:0] in_data,
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [DATA_BITS-1:0] out_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [DATA_BITS-1:0] mem [DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [CNT_BITS-1:0]  count;
  logic                 push;
  logic                 pop;

  // Pointer advance with wrap, depth need not be a power of two.
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Status from the registered count only.
  assign in_ready  = (count != CNT_BITS'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Storage.
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers and occupancy.
  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Pointers meet only when the queue is empty or full.
  a_ptr_match: assert property (@(posedge aclk) disable iff (reset)
    (wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_BITS'(DEPTH))));

endmodule

// File: dma_cpl_assign.sv
`timescale 1ns/10ps

/*
 * Completion assign.
 * Passes a channel's descriptors downstream and queues the metadata
 * of every accepted control request. Each downstream done pops the
 * oldest entry and returns it to the channel.
 */
module dma_cpl_assign import dma_pkg::*; #(
  parameter int N_OUTSTANDING = 8
) (
  input  logic aclk,
  input  logic reset,
  dma_intf.s   s_req,
  dma_intf.m   m_req
);

  logic      meta_in_valid;
  logic      meta_in_ready;
  dma_done_t meta_in;
  logic      meta_out_valid;
  dma_done_t meta_out;

  // ********************************************************************
  // Request path.
  // ********************************************************************

  // Valid held off while the metadata queue is full.
  // Kept independent of downstream ready.
  assign m_req.valid = s_req.valid & meta_in_ready;
  assign m_req.req   = s_req.req;
  assign s_req.ready = m_req.ready & meta_in_ready;

  // Only control requests expect a completion.
  assign meta_in_valid = m_req.valid & m_req.ready & m_req.req.ctl;

  assign meta_in = '{
    host:   m_req.req.host,
    stream: m_req.req.stream,
    dest:   m_req.req.dest,
    pid:    m_req.req.pid
  };

  // ********************************************************************
  // Completion path.
  // ********************************************************************

  // Done passes straight up with the queue head.
  assign s_req.done = m_req.done;
  assign s_req.cpl  = meta_out;

  cpl_queue #(
    .DATA_BITS ($bits(dma_done_t)),
    .DEPTH     (N_OUTSTANDING)
  ) meta_queue (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (meta_in_valid),
    .in_ready  (meta_in_ready),
    .in_data   (meta_in),
    .out_valid (meta_out_valid),
    .out_ready (m_req.done),
    .out_data  (meta_out)
  );

  // Downstream never completes more than was issued on this channel.
  a_done_has_meta: assert property (@(posedge aclk) disable iff (reset)
    m_req.done |-> meta_out_valid);

endmodule

// File: dma_intf.sv
`timescale 1ns/10ps

/*
 * DMA request interface.
 * One descriptor valid/ready handshake plus the completion return,
 * a single-cycle done pulse with its metadata.
 */
interface dma_intf import dma_pkg::*; ();

  // Request side, master to slave.
  logic      valid;
  logic      ready;
  dma_req_t  req;

  // Completion side, slave to master.
  // No ready here, done is a pulse.
  logic      done;
  dma_done_t cpl;

  // Issuer of descriptors.
  modport m (
    output valid,
    output req,
    input  ready,
    input  done,
    input  cpl
  );

  // Receiver of descriptors.
  modport s (
    input  valid,
    input  req,
    output ready,
    output done,
    output cpl
  );

endinterface

// File: dma_pkg.sv
/*
 * DMA request path definitions.
 * Field widths, the request descriptor and the completion metadata
 * shared by the completion assign blocks, the arbiter and the top.
 */
package dma_pkg;

  // ********************************************************************
  // Field widths.
  // ********************************************************************
  localparam int ADDR_BITS = 32;
  localparam int LEN_BITS  = 16;
  localparam int PID_BITS  = 6;
  localparam int DEST_BITS = 4;

  // ********************************************************************
  // Request descriptor, 61 bits.
  // ********************************************************************
  typedef struct packed {
    logic [ADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]  len;
    // Completion requested.
    logic                 ctl;
    logic [PID_BITS-1:0]  pid;
    logic [DEST_BITS-1:0] dest;
    logic                 stream;
    logic                 host;
  } dma_req_t;

  // ********************************************************************
  // Completion metadata, 12 bits.
  // ********************************************************************
  typedef struct packed {
    logic                 host;
    logic                 stream;
    logic [DEST_BITS-1:0] dest;
    logic [PID_BITS-1:0]  pid;
  } dma_done_t;

endpackage

// File: dma_req_input.txt
// chan vaddr len ctl pid dest stream host, all hex.
// One descriptor per line, each test replays the whole list.
0 10000000 0040 1 01 2 0 1
1 20001000 0100 0 11 5 1 0
0 10000040 0080 1 02 3 1 1
1 20001100 0200 1 12 6 0 1
0 100000c0 0010 0 03 4 0 0
1 20001300 0020 1 13 7 1 1
0 100000d0 1000 1 3f f 1 0
1 20001320 0008 0 14 8 0 0
0 100010d0 0004 1 04 1 0 1
1 20001328 ffff 1 2a 9 1 0
0 100010d4 0200 1 05 0 1 1
1 2001f000 0400 0 15 a 0 1

// File: dma_req_top.sv
`timescale 1ns/10ps

/*
 * DMA request path top.
 * One completion assign block per user channel, merged by a
 * round-robin arbiter onto the downstream request bus.
 */
module dma_req_top import dma_pkg::*; #(
  parameter int N_CHAN        = 2,
  parameter int N_OUTSTANDING = 8
) (
  input  logic                                aclk,
  input  logic                                reset,

  // User channels.
  input  logic [N_CHAN-1:0]                   req_valid,
  output logic [N_CHAN-1:0]                   req_ready,
  input  logic [N_CHAN-1:0][ADDR_BITS-1:0]    req_vaddr,
  input  logic [N_CHAN-1:0][LEN_BITS-1:0]     req_len,
  input  logic [N_CHAN-1:0]                   req_ctl,
  input  logic [N_CHAN-1:0][PID_BITS-1:0]     req_pid,
  input  logic [N_CHAN-1:0][DEST_BITS-1:0]    req_dest,
  input  logic [N_CHAN-1:0]                   req_stream,
  input  logic [N_CHAN-1:0]                   req_host,
  output logic [N_CHAN-1:0]                   done,
  output logic [N_CHAN-1:0][PID_BITS-1:0]     done_pid,
  output logic [N_CHAN-1:0][DEST_BITS-1:0]    done_dest,
  output logic [N_CHAN-1:0]                   done_stream,
  output logic [N_CHAN-1:0]                   done_host,

  // Downstream DMA engine.
  output logic                                m_valid,
  input  logic                                m_ready,
  output logic [ADDR_BITS-1:0]                m_vaddr,
  output logic [LEN_BITS-1:0]                 m_len,
  output logic                                m_ctl,
  output logic [PID_BITS-1:0]                 m_pid,
  output logic [DEST_BITS-1:0]                m_dest,
  output logic                                m_stream,
  output logic                                m_host,
  input  logic                                m_done
);

  // User side, assign to arbiter, arbiter to engine.
  dma_intf chan_req [N_CHAN] ();
  dma_intf arb_req  [N_CHAN] ();
  dma_intf dma_req ();

  // ********************************************************************
  // Channels.
  // ********************************************************************
  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign chan_req[i].valid = req_valid[i];
    assign chan_req[i].req   = '{
      vaddr:  req_vaddr[i],
      len:    req_len[i],
      ctl:    req_ctl[i],
      pid:    req_pid[i],
      dest:   req_dest[i],
      stream: req_stream[i],
      host:   req_host[i]
    };

    assign req_ready[i]   = chan_req[i].ready;
    assign done[i]        = chan_req[i].done;
    assign done_pid[i]    = chan_req[i].cpl.pid;
    assign done_dest[i]   = chan_req[i].cpl.dest;
    assign done_stream[i] = chan_req[i].cpl.stream;
    assign done_host[i]   = chan_req[i].cpl.host;

    dma_cpl_assign #(
      .N_OUTSTANDING (N_OUTSTANDING)
    ) cpl_assign (
      .aclk  (aclk),
      .reset (reset),
      .s_req (chan_req[i]),
      .m_req (arb_req[i])
    );
  end

  // ********************************************************************
  // Arbiter and downstream bus.
  // ********************************************************************
  dma_rr_arbiter #(
    .N_CHAN        (N_CHAN),
    .N_OUTSTANDING (N_OUTSTANDING)
  ) arbiter (
    .aclk  (aclk),
    .reset (reset),
    .s_req (arb_req),
    .m_req (dma_req)
  );

  assign m_valid       = dma_req.valid;
  assign dma_req.ready = m_ready;
  assign m_vaddr       = dma_req.req.vaddr;
  assign m_len         = dma_req.req.len;
  assign m_ctl         = dma_req.req.ctl;
  assign m_pid         = dma_req.req.pid;
  assign m_dest        = dma_req.req.dest;
  assign m_stream      = dma_req.req.stream;
  assign m_host        = dma_req.req.host;
  assign dma_req.done  = m_done;

  // Engine returns a bare pulse.
  // Metadata comes from the assign blocks.
  assign dma_req.cpl = '0;

endmodule

// File: dma_rr_arbiter.sv
`timescale 1ns/10ps

/*
 * Round-robin DMA arbiter.
 * Merges the channel request interfaces onto one downstream bus.
 * Records the channel of every control request that passes and
 * steers each in-order completion back to that channel.
 */
module dma_rr_arbiter import dma_pkg::*; #(
  parameter int N_CHAN        = 2,
  parameter int N_OUTSTANDING = 8
) (
  input  logic aclk,
  input  logic reset,
  dma_intf.s   s_req [N_CHAN],
  dma_intf.m   m_req
);

  localparam int IDX_BITS = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

  logic [N_CHAN-1:0]   chan_valid;
  dma_req_t            chan_req [N_CHAN];
  logic [N_CHAN-1:0]   grant;
  logic [IDX_BITS-1:0] grant_idx;
  logic                any_valid;
  logic [IDX_BITS-1:0] rr_ptr;
  logic                accept;
  logic                id_in_ready;
  logic                id_out_valid;
  logic [IDX_BITS-1:0] id_head;

  // ********************************************************************
  // Per-channel wiring.
  // ********************************************************************
  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign chan_valid[i] = s_req[i].valid;
    assign chan_req[i]   = s_req[i].req;

    // Granted channel only, and only when the id can be recorded.
    assign s_req[i].ready = grant[i] & m_req.ready & id_in_ready;

    // Completion goes to the channel at the head of the id queue.
    assign s_req[i].done = m_req.done & (id_head == IDX_BITS'(i));
    assign s_req[i].cpl  = m_req.cpl;
  end

  // ********************************************************************
  // Grant selection.
  // ********************************************************************

  // First valid channel at or after the pointer.
  // Walk backwards so the nearest one wins.
  always_comb begin
    int idx;
    grant_idx = '0;
    for (int k = N_CHAN - 1; k >= 0; k--) begin
      idx = int'(rr_ptr) + k;
      if (idx >= N_CHAN) begin
        idx = idx - N_CHAN;
      end
      if (chan_valid[idx]) begin
        grant_idx = IDX_BITS'(idx);
      end
    end
  end

  assign any_valid = |chan_valid;
  assign grant     = any_valid ? (N_CHAN'(1) << grant_idx) : '0;

  // Downstream bus.
  assign m_req.valid = any_valid & id_in_ready;
  assign m_req.req   = chan_req[grant_idx];
  assign accept      = m_req.valid & m_req.ready;

  // Pointer moves just past the channel served.
  always_ff @(posedge aclk) begin
    if (reset) begin
      rr_ptr <= '0;
    end else if (accept) begin
      if (grant_idx == IDX_BITS'(N_CHAN - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_idx + 1'b1;
      end
    end
  end

  // ********************************************************************
  // Channel ids of outstanding control requests.
  // ********************************************************************

  // Room for every channel's full set of outstanding requests.
  cpl_queue #(
    .DATA_BITS (IDX_BITS),
    .DEPTH     (N_CHAN * N_OUTSTANDING)
  ) id_queue (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (accept & m_req.req.ctl),
    .in_ready  (id_in_ready),
    .in_data   (grant_idx),
    .out_valid (id_out_valid),
    .out_ready (m_req.done),
    .out_data  (id_head)
  );

  // Grant lands on a requesting channel.
  // The pointer's own channel wins whenever it requests.
  a_grant_valid: assert property (@(posedge aclk) disable iff (reset)
    any_valid |-> chan_valid[grant_idx] && (!chan_valid[rr_ptr] || grant_idx == rr_ptr));

  // Every downstream completion matches a recorded control request.
  a_done_has_id: assert property (@(posedge aclk) disable iff (reset)
    m_req.done |-> id_out_valid);

endmodule

// File: files.f
dma_pkg.sv
dma_intf.sv
cpl_queue.sv
dma_cpl_assign.sv
dma_rr_arbiter.sv
dma_req_top.sv
tb_dma_req_top.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA request path testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dma_req_top -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_dma_req_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// File: tb_dma_req_top.sv
`timescale 1ns/10ps

/*
 * Testbench for the DMA request path top.
 * Replays the descriptor file on both channels, models the DMA engine
 * with in-order completions and checks fields, routing, back-pressure
 * and round-robin order.
 */
module tb_dma_req_top import dma_pkg::*; ();

  localparam int N_OUT   = 4;
  localparam int NMAX    = 16;
  localparam int N_TESTS = 4;

  logic                      aclk = 1'b0;
  logic                      reset;
  logic [1:0]                req_valid, req_ready, req_ctl, req_stream, req_host;
  logic [1:0][ADDR_BITS-1:0] req_vaddr;
  logic [1:0][LEN_BITS-1:0]  req_len;
  logic [1:0][PID_BITS-1:0]  req_pid, done_pid;
  logic [1:0][DEST_BITS-1:0] req_dest, done_dest;
  logic [1:0]                done, done_stream, done_host;
  logic                      m_valid, m_ready, m_ctl, m_stream, m_host, m_done;
  logic [ADDR_BITS-1:0]      m_vaddr;
  logic [LEN_BITS-1:0]       m_len;
  logic [PID_BITS-1:0]       m_pid;
  logic [DEST_BITS-1:0]      m_dest;

  // Eight words per descriptor, in file column order.
  logic [31:0] stim [8*NMAX];
  int          list_idx [2][NMAX];
  int          list_len [2];
  int          pos [2];
  int          pending [$];
  int          out_cnt [2], ctl_cnt [2], done_cnt [2];
  int          errors, err_start, tests_failed, n_desc, last_ch;
  int          ready_mode, cpl_mode;
  bit          gap_en, alt_chk, loaded;
  logic [1:0]  taken;
  logic [31:0] rng;

  always #4 aclk = ~aclk;

  dma_req_top #(.N_CHAN(2), .N_OUTSTANDING(N_OUT)) dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: expected %h, got %h at %0t", name, exp, got, $time);
      errors++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  // ******************************************************************
  // Monitor, sampled at the falling edge.
  // ******************************************************************
  task automatic sample_outputs();
    int k;
    int ch;
    taken = req_valid & req_ready;
    if (!m_ready && req_ready != 2'b00) begin
      note_error("a channel is ready while m_ready is low");
    end
    if (ready_mode == 1 && req_valid != 2'b00 && !m_valid) begin
      note_error("m_valid dropped during the m_ready stall");
    end
    // Full completion queue blocks the channel.
    for (int c = 0; c < 2; c++) begin
      if (out_cnt[c] == N_OUT && req_ready[c]) begin
        note_error($sformatf("channel %0d ready with %0d completions open", c, N_OUT));
      end
    end
    // Completion belongs to the oldest open control request.
    if (m_done) begin
      k  = pending.pop_front();
      ch = int'(stim[8*k]);
      check_value("done", 32'(done), 32'(1) << ch);
      check_value("done_pid", 32'(done_pid[ch]), stim[8*k+4]);
      check_value("done_dest", 32'(done_dest[ch]), stim[8*k+5]);
      check_value("done_stream", 32'(done_stream[ch]), stim[8*k+6]);
      check_value("done_host", 32'(done_host[ch]), stim[8*k+7]);
      out_cnt[ch]--;
    end else begin
      check_value("done", 32'(done), 32'h0);
    end
    // Done pulses seen on each channel.
    for (int c = 0; c < 2; c++) begin
      if (done[c]) begin
        done_cnt[c]++;
      end
    end
    // Downstream transfer, next descriptor of exactly one channel.
    if (m_valid && m_ready) begin
      if (!$onehot(taken)) begin
        note_error("downstream transfer without exactly one channel handshake");
      end else begin
        ch = taken[1] ? 1 : 0;
        k  = list_idx[ch][pos[ch]];
        check_value("m_vaddr", m_vaddr, stim[8*k+1]);
        check_value("m_len", 32'(m_len), stim[8*k+2]);
        check_value("m_ctl", 32'(m_ctl), stim[8*k+3]);
        check_value("m_pid", 32'(m_pid), stim[8*k+4]);
        check_value("m_dest", 32'(m_dest), stim[8*k+5]);
        check_value("m_stream", 32'(m_stream), stim[8*k+6]);
        check_value("m_host", 32'(m_host), stim[8*k+7]);
        if (alt_chk && req_valid == 2'b11 && ch == last_ch) begin
          note_error($sformatf("channel %0d granted twice in a row", ch));
        end
        last_ch = ch;
        pos[ch]++;
        if (stim[8*k+3][0]) begin
          pending.push_back(k);
          out_cnt[ch]++;
          ctl_cnt[ch]++;
        end
      end
    end else if (taken != 2'b00) begin
      note_error("channel handshake without a downstream transfer");
    end
  endtask

  // ******************************************************************
  // Channel drivers and engine model, 1 ns after the rising edge.
  // ******************************************************************
  task automatic drive_inputs();
    int b;
    rng = xorshift(rng);
    m_ready = (ready_mode == 2) || (ready_mode == 0 && rng[1:0] != 2'b00);
    // Engine completes in order, after a random delay.
    m_done = (pending.size() > 0) && (cpl_mode == 2 || (cpl_mode == 1 && rng[3:2] == 2'b00));
    for (int c = 0; c < 2; c++) begin
      // Valid holds until the handshake.
      if (taken[c] || !req_valid[c]) begin
        rng = xorshift(rng);
        if (pos[c] < list_len[c] && (!gap_en || rng[0])) begin
          b = 8 * list_idx[c][pos[c]];
          req_valid[c]  = 1'b1;
          req_vaddr[c]  = stim[b+1];
          req_len[c]    = stim[b+2][LEN_BITS-1:0];
          req_ctl[c]    = stim[b+3][0];
          req_pid[c]    = stim[b+4][PID_BITS-1:0];
          req_dest[c]   = stim[b+5][DEST_BITS-1:0];
          req_stream[c] = stim[b+6][0];
          req_host[c]   = stim[b+7][0];
        end else begin
          req_valid[c] = 1'b0;
        end
      end
    end
  endtask

  task automatic step();
    @(negedge aclk);
    if (!reset) begin
      sample_outputs();
    end
    @(posedge aclk);
    #1;
    drive_inputs();
  endtask

  task automatic start_test(input int rmode, input int cmode, input bit gaps);
    err_start  = errors;
    ready_mode = rmode;
    cpl_mode   = cmode;
    gap_en     = gaps;
    pos[0]     = 0;
    pos[1]     = 0;
  endtask

  // Waits for both lists to go out and all completions to return.
  task automatic finish_test(input string name);
    while (pos[0] < list_len[0] || pos[1] < list_len[1] || pending.size() != 0) begin
      step();
    end
    repeat (2) step();
    for (int c = 0; c < 2; c++) begin
      if (done_cnt[c] != ctl_cnt[c]) begin
        note_error($sformatf("channel %0d saw %0d dones for %0d control requests",
                             c, done_cnt[c], ctl_cnt[c]));
      end
    end
    if (errors == err_start) begin
      $display("%-20s ok", name);
    end else begin
      tests_failed++;
      $display("%-20s FAILED with %0d errors", name, errors - err_start);
    end
  endtask

  // Watchdog, 200 cycles per descriptor sent plus 1000.
  initial begin
    wait (loaded);
    repeat (200 * n_desc * N_TESTS + 1000) @(posedge aclk);
    $display("Timeout: the tests did not finish within the cycle limit");
    $display("test failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    {req_valid, req_ctl, req_stream, req_host} = '0;
    {req_vaddr, req_len, req_pid, req_dest} = '0;
    {m_ready, m_done} = 2'b00;
    errors       = 0;
    tests_failed = 0;
    n_desc       = 0;
    last_ch      = 0;
    out_cnt  = '{0, 0};
    ctl_cnt  = '{0, 0};
    done_cnt = '{0, 0};
    list_len = '{0, 0};
    taken    = 2'b00;
    rng      = 32'h33732251;
    // Unused slots keep an all-ones channel word.
    for (int i = 0; i < 8 * NMAX; i++) begin
      stim[i] = '1;
    end
    $readmemh("dma_req_input.txt", stim);
    for (int k = 0; k < NMAX; k++) begin
      if (stim[8*k] != 32'hffffffff) begin
        list_idx[stim[8*k][0]][list_len[stim[8*k][0]]] = k;
        list_len[stim[8*k][0]]++;
        n_desc++;
      end
    end
    pos[0] = list_len[0];
    pos[1] = list_len[1];
    ready_mode = 2;
    cpl_mode   = 1;
    gap_en     = 1'b0;
    alt_chk    = 1'b0;
    loaded = 1'b1;
    repeat (4) step();
    reset = 1'b0;

    start_test(0, 1, 1'b1);
    finish_test("random traffic");

    // Downstream held off for a stretch.
    start_test(1, 1, 1'b0);
    repeat (20) step();
    ready_mode = 0;
    finish_test("m_ready stall");

    // Channel 0 alone, completions withheld until its queue fills.
    start_test(2, 0, 1'b0);
    pos[1] = list_len[1];
    while (out_cnt[0] < N_OUT) begin
      step();
    end
    repeat (10) step();
    if (pos[0] == list_len[0]) begin
      note_error("channel 0 finished its list with completions withheld");
    end
    cpl_mode = 1;
    finish_test("outstanding limit");

    start_test(2, 2, 1'b0);
    alt_chk = 1'b1;
    finish_test("round-robin order");
    alt_chk = 1'b0;

    $display("%0d tests run, %0d failed, %0d check errors", N_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
